// File: bench/sprint1_trace.txt
# S <byte count> <hex bytes> | V <video hex> <cycles> | A <audio hex> <cycles>
# E C <core_ctrl hex> | E G <vga hex> | E D <audio code hex, ones per 128 cycles>
E C 3F9
S 5 1E 01 00 00 00
E C 1F9
S 5 1E 00 00 00 00
E C 3F9
S 5 1E 02 00 00 00
E C 3F8
S 5 1E 00 00 00 00
S 2 01 02
E C 1F9
S 2 01 00
E C 3F9
S 2 02 72
E C 3C5
S 2 02 00
E C 3F9
S 2 05 2E
E C 2F9
S 2 05 16
E C 2B9
S 2 05 E0
S 2 05 74
E C 2BB
S 2 05 F0
S 2 05 2E
E C 3BB
S 2 05 F0
S 2 05 16
E C 3FB
S 2 05 E0
S 2 05 F0
S 2 05 74
E C 3F9
V A42 4
E G 00003
V A40 4
E G A69A7
V FF1 4
E G 00003
S 5 1E 10 00 00 00
V A48 4
E G 55555
V A40 4
E G 55557
S 5 1E 18 00 00 00
E G 2CB2F
V A48 4
E G A69A5
V A40 4
V A48 4
E G 2CB2D
S 2 01 10
E G A69A5
S 2 01 50
E G A69A6
V A44 4
E G A69A5
S 2 01 00
S 5 1E 00 00 00 00
A 00 200
E D 00
A 40 200
E D 40
A 15 200
E D 15
A 7F 200
E D 7F

// File: verilog.f
+incdir+common
common/mist_pkg.sv
user_io/user_io.sv
rtl/arcade_inputs.sv
mist_video/mist_video.sv
rtl/dac.sv
rtl/sprint1_shell.sv
bench/sprint1_checker.sv
bench/sprint1_assert.sv
bench/tb_sprint1_shell.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_sprint1_shell -o sim_tb \
	&& out="$(./obj_dir/sim_tb)" \
	|| { echo "$out"; echo "Build or run failed"; exit 1; }

echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" || exit 1
exit 0

// File: bench/tb_sprint1_shell.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sprint1_shell import mist_pkg::*; ();

	localparam logic [31:0] SEED = 32'hba72_dc90;

	logic       clk_24;
	logic       arst_n;
	logic       spi_sck;
	logic       spi_di;
	logic       conf_data0;
	video_in_t  core_video;
	logic [6:0] core_audio;
	vga_t       vga;
	logic       audio_l;
	logic       audio_r;
	core_ctrl_t core_ctrl;

	logic        chk_req;
	logic [7:0]  chk_kind;
	logic [31:0] chk_value;
	logic        chk_done;
	int          checks;
	int          errors;

	// Trace records, loaded before the run starts
	logic [7:0]  rec_kind[$];
	logic [31:0] rec_a[$];
	logic [31:0] rec_b[$];
	logic [7:0]  spi_q[$];
	int          trace_errors = 0;
	int          cycle_limit = 0;
	int          cycles = 0;

	sprint1_shell u_dut (
		.clk_24     (clk_24),
		.arst_n     (arst_n),
		.spi_sck    (spi_sck),
		.spi_di     (spi_di),
		.conf_data0 (conf_data0),
		.core_video (core_video),
		.core_audio (core_audio),
		.vga        (vga),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.core_ctrl  (core_ctrl)
	);

	sprint1_checker u_checker (
		.clk_24    (clk_24),
		.core_ctrl (core_ctrl),
		.vga       (vga),
		.audio_l   (audio_l),
		.req       (chk_req),
		.kind      (chk_kind),
		.value     (chk_value),
		.done      (chk_done),
		.checks    (checks),
		.errors    (errors)
	);

	initial begin
		clk_24 = 1'b0;
		forever #2 clk_24 = ~clk_24;
	end

	always @(posedge clk_24) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Run timed out after %0d cycles without reaching the end of the trace",
				cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ==================================================
	// Stimulus tasks
	// ==================================================
	task automatic spi_transfer(input int n);
		logic [7:0] b;
		conf_data0 <= 1'b0;
		repeat (4) @(posedge clk_24);
		for (int i = 0; i < n; i++) begin
			b = spi_q.pop_front();
			for (int k = 7; k >= 0; k--) begin // MSB first, sck at clk/8
				spi_di  <= b[k];
				spi_sck <= 1'b0;
				repeat (4) @(posedge clk_24);
				spi_sck <= 1'b1;
				repeat (4) @(posedge clk_24);
			end
			spi_sck <= 1'b0;
			repeat ($urandom % 4) @(posedge clk_24);
		end
		repeat (4) @(posedge clk_24);
		conf_data0 <= 1'b1;
		repeat (8) @(posedge clk_24); // Outputs settle within 4 cycles of the last edge
	endtask

	task automatic request_check(input logic [7:0] kind, input logic [31:0] value);
		chk_req   <= 1'b1;
		chk_kind  <= kind;
		chk_value <= value;
		@(posedge clk_24);
		chk_req <= 1'b0;
		@(posedge clk_24);
		while (!chk_done)
			@(posedge clk_24);
	endtask

	task automatic load_trace(input int fd);
		logic [7:0]  ch;
		logic [7:0]  sub;
		logic [31:0] v;
		logic [7:0]  b;
		int          n;
		string       line;
		int          total;
		total = 0;
		while ($fscanf(fd, " %c", ch) == 1) begin
			case (ch)
				"#": void'($fgets(line, fd));
				"S": begin
					void'($fscanf(fd, "%d", n));
					for (int i = 0; i < n; i++) begin
						void'($fscanf(fd, "%h", b));
						spi_q.push_back(b);
					end
					rec_kind.push_back(ch);
					rec_a.push_back(n);
					rec_b.push_back(0);
					total += n * 72 + 30;
				end
				"V", "A": begin
					void'($fscanf(fd, "%h %d", v, n));
					rec_kind.push_back(ch);
					rec_a.push_back(v);
					rec_b.push_back(n);
					total += n;
				end
				"E": begin
					void'($fscanf(fd, " %c %h", sub, v));
					rec_kind.push_back(ch);
					rec_a.push_back({24'd0, sub});
					rec_b.push_back(v);
					total += (sub == "D") ? 140 : 4;
				end
				default: begin
					$display("Trace holds an unknown record type '%c'", ch);
					trace_errors++;
				end
			endcase
		end
		cycle_limit = total * 2 + 1000;
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int          fd;
		logic [7:0]  kind;
		logic [31:0] a;
		logic [31:0] b;
		void'($urandom(SEED));
		arst_n     = 1'b0;
		spi_sck    = 1'b0;
		spi_di     = 1'b0;
		conf_data0 = 1'b1;
		core_video = '0;
		core_audio = '0;
		chk_req    = 1'b0;
		chk_kind   = '0;
		chk_value  = '0;

		fd = $fopen("bench/sprint1_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file bench/sprint1_trace.txt");
			trace_errors++;
		end else begin
			load_trace(fd);
			$fclose(fd);
		end

		repeat (10) @(posedge clk_24);
		arst_n <= 1'b1;
		@(posedge clk_24);

		while (rec_kind.size() > 0) begin
			kind = rec_kind.pop_front();
			a    = rec_a.pop_front();
			b    = rec_b.pop_front();
			case (kind)
				"S": spi_transfer(a);
				"V": begin
					core_video <= video_in_t'(a[11:0]);
					repeat (b) @(posedge clk_24);
				end
				"A": begin
					core_audio <= a[6:0];
					repeat (b) @(posedge clk_24);
				end
				default: request_check(a[7:0], b);
			endcase
		end

		$display("Checks run: %0d, errors: %0d, trace problems: %0d",
			checks, errors, trace_errors);
		if (errors == 0 && trace_errors == 0 && checks > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/sprint1_assert.sv
`timescale 1ns/100ps
`default_nettype none

module sprint1_assert import mist_pkg::*; (
	input wire logic clk_24,
	input wire logic arst_n,
	input wire logic key_strobe,
	input wire logic audio_l,
	input wire logic audio_r,
	input wire vga_t vga
);

	a_strobe_single: assert property (@(posedge clk_24) disable iff (!arst_n)
		key_strobe |=> !key_strobe)
		else $error("key_strobe high on two cycles in a row");

	a_audio_mono: assert property (@(posedge clk_24) audio_r == audio_l)
		else $error("audio_r differs from audio_l");

	a_vga_reset: assert property (@(posedge clk_24) !arst_n |-> vga == '0)
		else $error("vga not zero during reset");

	// Monochrome source, so all three channels match
	a_vga_grey: assert property (@(posedge clk_24) disable iff (!arst_n)
		vga.r == vga.g && vga.g == vga.b)
		else $error("vga colour channels differ");

endmodule

bind sprint1_shell sprint1_assert u_assert (
	.clk_24     (clk_24),
	.arst_n     (arst_n),
	.key_strobe (key_strobe),
	.audio_l    (audio_l),
	.audio_r    (audio_r),
	.vga        (vga)
);

`default_nettype wire

// File: bench/sprint1_checker.sv
`timescale 1ns/100ps
`default_nettype none

module sprint1_checker import mist_pkg::*; (
	input  wire logic        clk_24,
	input  wire core_ctrl_t  core_ctrl,
	input  wire vga_t        vga,
	input  wire logic        audio_l,
	input  wire logic        req,
	input  wire logic [7:0]  kind,
	input  wire logic [31:0] value,
	output logic             done = 1'b0,
	output int               checks = 0,
	output int               errors = 0
);

	logic        counting = 1'b0;
	int          window = 0;
	int          ones = 0;
	logic [31:0] want = '0;

	// Outputs are sampled on the falling edge, half a cycle away from any update
	always @(negedge clk_24) begin
		if (req) begin
			case (kind)
				"C": begin
					checks++;
					if (core_ctrl !== value[9:0]) begin
						errors++;
						$display("[ERROR] %0t ns check %0d core_ctrl got %03h expected %03h",
							$time, checks, core_ctrl, value[9:0]);
					end else
						$display("Check %0d core_ctrl %03h ok", checks, value[9:0]);
					done <= 1'b1;
				end
				"G": begin
					checks++;
					if (vga !== value[19:0]) begin
						errors++;
						$display("[ERROR] %0t ns check %0d vga got %05h expected %05h",
							$time, checks, vga, value[19:0]);
					end else
						$display("Check %0d vga %05h ok", checks, value[19:0]);
					done <= 1'b1;
				end
				"D": begin
					done     <= 1'b0;
					counting <= 1'b1;
					window    = 0;
					ones      = 0;
					want      = value;
				end
				default: begin
					checks++;
					errors++;
					$display("Check %0d has an unknown expectation type", checks);
					done <= 1'b1;
				end
			endcase
		end else if (counting) begin
			ones += audio_l;
			window++;
			if (window == 128) begin // 128 cycles hold exactly code ones, give or take one
				checks++;
				counting <= 1'b0;
				done     <= 1'b1;
				if (ones > int'(want) + 1 || ones < int'(want) - 1) begin
					errors++;
					$display("[ERROR] %0t ns check %0d audio ones %0d expected %0d",
						$time, checks, ones, want);
				end else
					$display("Check %0d audio code %0d ok with %0d ones", checks, want, ones);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/sprint1_shell.sv
`timescale 1ns/100ps
`default_nettype none
`include "mist_config.svh"

module sprint1_shell import mist_pkg::*; (
	input  wire logic                 clk_24,
	input  wire logic                 arst_n,
	input  wire logic                 spi_sck,
	input  wire logic                 spi_di,
	input  wire logic                 conf_data0,
	input  wire video_in_t            core_video,
	input  wire logic [`DAC_BITS-1:0] core_audio,
	output vga_t                      vga,
	output logic                      audio_l,
	output logic                      audio_r,
	output core_ctrl_t                core_ctrl
);

	logic [`STATUS_BITS-1:0] status;
	sw_cfg_t                 sw_cfg;
	joy_t                    joystick_0;
	joy_t                    player1;
	ctrl_t                   controls;
	logic                    key_strobe;
	logic                    key_pressed;
	logic [7:0]              key_code;
	logic                    key_ext;
	scan_mode_e              scanlines;

	// ==================================================
	// Blocks
	// ==================================================
	user_io u_user_io (
		.clk_24      (clk_24),
		.arst_n      (arst_n),
		.spi_sck     (spi_sck),
		.spi_di      (spi_di),
		.conf_data0  (conf_data0),
		.status      (status),
		.sw_cfg      (sw_cfg),
		.joystick_0  (joystick_0),
		.joystick_1  (),           // Sprint 1 is single player
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.key_ext     (key_ext)
	);

	arcade_inputs u_inputs (
		.clk_24      (clk_24),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.key_ext     (key_ext),
		.joystick_0  (joystick_0),
		.player1     (player1),
		.controls    (controls)
	);

	assign scanlines = scan_mode_e'(status[4:3]);

	mist_video u_video (
		.clk_24     (clk_24),
		.arst_n     (arst_n),
		.core_video (core_video),
		.scanlines  (scanlines),
		.sw_cfg     (sw_cfg),
		.vga        (vga)
	);

	dac #(.C_BITS(`DAC_BITS)) u_dac (
		.clk_24  (clk_24),
		.arst_n  (arst_n),
		.dac_in  (core_audio),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l; // Mono game

	// Core inputs are mostly active low
	always_comb begin
		core_ctrl.reset_n    = ~(status[0] | sw_cfg.buttons[1]);
		core_ctrl.coin1_n    = ~controls.coin1;
		core_ctrl.coin2_n    = ~controls.coin2;
		core_ctrl.start_n    = ~controls.one_player;
		core_ctrl.gas_n      = ~player1.fire_a;
		core_ctrl.gearup_n   = ~player1.fire_b;
		core_ctrl.geardown_n = ~player1.fire_c;
		core_ctrl.left       = player1.left;
		core_ctrl.right      = player1.right;
		core_ctrl.test_n     = ~status[1];
	end

endmodule

`default_nettype wire

// File: rtl/dac.sv
`timescale 1ns/100ps
`default_nettype none
`include "mist_config.svh"

module dac #(
	parameter int C_BITS = `DAC_BITS
) (
	input  wire logic              clk_24,
	input  wire logic              arst_n,
	input  wire logic [C_BITS-1:0] dac_in,
	output logic                   dac_out
);

	logic [C_BITS-1:0] acc;
	logic [C_BITS:0]   sum;

	assign sum = {1'b0, acc} + {1'b0, dac_in}; // Top bit is the carry

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[C_BITS-1:0];
			dac_out <= sum[C_BITS];
		end
	end

endmodule

`default_nettype wire

// File: mist_video/mist_video.sv
`timescale 1ns/100ps
`default_nettype none
`include "mist_config.svh"

module mist_video import mist_pkg::*; (
	input  wire logic       clk_24,
	input  wire logic       arst_n,
	input  wire video_in_t  core_video,
	input  wire scan_mode_e scanlines,
	input  wire sw_cfg_t    sw_cfg,
	output vga_t            vga
);

	// ==================================================
	// Stage 1 blanking and line parity
	// ==================================================
	logic [`COLOR_DEPTH-1:0] luma_q;
	logic                    hs_q;
	logic                    vs_q;
	logic                    hs_prev;
	logic                    odd_line;

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			luma_q   <= '0;
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			hs_prev  <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			if (core_video.hb || core_video.vb)
				luma_q <= '0;
			else
				luma_q <= core_video.luma[7 -: `COLOR_DEPTH];
			hs_q    <= core_video.hs;
			vs_q    <= core_video.vs;
			hs_prev <= core_video.hs;
			if (core_video.hs && !hs_prev)
				odd_line <= ~odd_line;
		end
	end

	// ==================================================
	// Stage 2 scanlines and sync
	// ==================================================
	logic [`COLOR_DEPTH-1:0] dim_sub;
	logic [`COLOR_DEPTH-1:0] dimmed;

	always_comb begin
		case (scanlines)
			pct25:   dim_sub = luma_q >> 2;
			pct50:   dim_sub = luma_q >> 1;
			pct75:   dim_sub = (luma_q >> 1) + (luma_q >> 2);
			default: dim_sub = '0;
		endcase
		if (!odd_line || sw_cfg.scandoubler_disable)
			dim_sub = '0; // Only odd lines are darkened
	end

	assign dimmed = luma_q - dim_sub;

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			vga <= '0;
		end else begin
			vga.r <= dimmed; // Monochrome source
			vga.g <= dimmed;
			vga.b <= dimmed;
			if (!sw_cfg.no_csync) begin
				vga.hs <= ~(hs_q ^ vs_q);
				vga.vs <= 1'b1;
			end else begin
				vga.hs <= hs_q;
				vga.vs <= vs_q;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/arcade_inputs.sv
`timescale 1ns/100ps
`default_nettype none
`include "mist_config.svh"

module arcade_inputs import mist_pkg::*; (
	input  wire logic       clk_24,
	input  wire logic       arst_n,
	input  wire logic       key_strobe,
	input  wire logic       key_pressed,
	input  wire logic [7:0] key_code,
	input  wire logic       key_ext,
	input  wire joy_t       joystick_0,
	output joy_t            player1,
	output ctrl_t           controls
);

	joy_t  key_joy;  // Keys currently held, in joystick layout
	ctrl_t key_ctrl;

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			key_joy  <= '0;
			key_ctrl <= '0;
		end else if (key_strobe) begin
			// Arrows need the E0 prefix or they would alias the keypad
			case ({key_ext, key_code})
				{1'b1, `KEY_UP}:    key_joy.up    <= key_pressed;
				{1'b1, `KEY_DOWN}:  key_joy.down  <= key_pressed;
				{1'b1, `KEY_LEFT}:  key_joy.left  <= key_pressed;
				{1'b1, `KEY_RIGHT}: key_joy.right <= key_pressed;
				{1'b0, `KEY_CTRL},
				{1'b1, `KEY_CTRL}:  key_joy.fire_a <= key_pressed; // Either ctrl key
				{1'b0, `KEY_ALT},
				{1'b1, `KEY_ALT}:   key_joy.fire_b <= key_pressed;
				{1'b0, `KEY_SPACE}: key_joy.fire_c <= key_pressed;
				{1'b0, `KEY_1}:     key_ctrl.one_player <= key_pressed;
				{1'b0, `KEY_5}:     key_ctrl.coin1 <= key_pressed;
				{1'b0, `KEY_6}:     key_ctrl.coin2 <= key_pressed;
				default: ;
			endcase
		end
	end

	assign player1  = joystick_0 | key_joy;
	assign controls = key_ctrl;

endmodule

`default_nettype wire

// File: user_io/user_io.sv
`timescale 1ns/100ps
`default_nettype none
`include "mist_config.svh"

module user_io import mist_pkg::*; (
	input  wire logic                    clk_24,
	input  wire logic                    arst_n,
	input  wire logic                    spi_sck,
	input  wire logic                    spi_di,
	input  wire logic                    conf_data0,
	output logic [`STATUS_BITS-1:0]      status,
	output sw_cfg_t                      sw_cfg,
	output joy_t                         joystick_0,
	output joy_t                         joystick_1,
	output logic                         key_strobe,
	output logic                         key_pressed,
	output logic [7:0]                   key_code,
	output logic                         key_ext
);

	localparam int STATUS_BYTES = `STATUS_BITS / 8;

	typedef enum logic [1:0] {
		st_cmd,  // Waiting for the command byte
		st_data,
		st_skip  // Rest of the transfer is ignored
	} byte_state_e;

	// ==================================================
	// Synchronisers and bit shifter
	// ==================================================
	logic [`SPI_SYNC-1:0] sck_sync;
	logic [`SPI_SYNC-1:0] di_sync;
	logic [`SPI_SYNC-1:0] ss_sync;
	logic                 sck_d;
	logic                 ss;
	logic                 sck_rise;
	logic [6:0]           shift;
	logic [2:0]           bit_cnt;
	logic [7:0]           rx_byte;
	logic                 byte_done;

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			sck_sync <= '0;
			di_sync  <= '0;
			ss_sync  <= '1; // Deselected
			sck_d    <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[`SPI_SYNC-2:0], spi_sck};
			di_sync  <= {di_sync[`SPI_SYNC-2:0], spi_di};
			ss_sync  <= {ss_sync[`SPI_SYNC-2:0], conf_data0};
			sck_d    <= sck_sync[`SPI_SYNC-1];
		end
	end

	assign ss        = ss_sync[`SPI_SYNC-1];
	assign sck_rise  = sck_sync[`SPI_SYNC-1] & ~sck_d & ~ss;
	assign rx_byte   = {shift, di_sync[`SPI_SYNC-1]}; // Byte including the bit on this edge
	assign byte_done = sck_rise & (bit_cnt == 3'd7);

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			shift   <= '0;
			bit_cnt <= '0;
		end else if (ss) begin
			shift   <= '0;
			bit_cnt <= '0;
		end else if (sck_rise) begin
			shift   <= rx_byte[6:0];
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	// ==================================================
	// Byte decoder
	// ==================================================
	byte_state_e                      state;
	spi_cmd_e                         cmd;
	logic [$clog2(STATUS_BYTES)-1:0]  byte_cnt;
	logic [`STATUS_BITS-9:0]          status_sh;
	logic                             key_rel;
	logic                             key_e0;
	logic                             key_final;

	// A scancode byte that is not a prefix completes a key event
	assign key_final = byte_done & (state == st_data) & (cmd == cmd_ps2_kbd) &
		(rx_byte != `KEY_BREAK) & (rx_byte != `KEY_EXT);

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_cmd;
			cmd        <= cmd_buttons;
			byte_cnt   <= '0;
			status_sh  <= '0;
			status     <= '0;
			sw_cfg     <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			key_rel    <= 1'b0;
			key_e0     <= 1'b0;
			key_strobe <= 1'b0;
		end else begin
			key_strobe <= key_final;
			if (ss) begin
				state    <= st_cmd;
				byte_cnt <= '0;
			end else if (byte_done) begin
				case (state)
					st_cmd: begin
						case (spi_cmd_e'(rx_byte))
							cmd_buttons, cmd_joy0, cmd_joy1, cmd_ps2_kbd, cmd_status: begin
								cmd   <= spi_cmd_e'(rx_byte);
								state <= st_data;
							end
							default: state <= st_skip;
						endcase
					end
					st_data: begin
						state <= st_skip; // Most commands carry a single byte
						case (cmd)
							cmd_buttons: begin
								sw_cfg.buttons             <= rx_byte[1:0];
								sw_cfg.switches            <= rx_byte[3:2];
								sw_cfg.scandoubler_disable <= rx_byte[4];
								sw_cfg.no_csync            <= rx_byte[6];
							end
							cmd_joy0: joystick_0 <= joy_t'({2'b00, rx_byte});
							cmd_joy1: joystick_1 <= joy_t'({2'b00, rx_byte});
							cmd_ps2_kbd: begin
								if (rx_byte == `KEY_BREAK)
									key_rel <= 1'b1;
								else if (rx_byte == `KEY_EXT)
									key_e0 <= 1'b1;
								else begin
									key_rel <= 1'b0;
									key_e0  <= 1'b0;
								end
							end
							cmd_status: begin
								byte_cnt <= byte_cnt + 1'b1;
								if (byte_cnt == STATUS_BYTES - 1)
									status <= {rx_byte, status_sh}; // All four bytes at once
								else begin
									status_sh[byte_cnt*8 +: 8] <= rx_byte;
									state                      <= st_data;
								end
							end
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_24) begin
		if (key_final) begin
			key_pressed <= ~key_rel;
			key_code    <= rx_byte;
			key_ext     <= key_e0;
		end
	end

endmodule

`default_nettype wire

// File: common/mist_pkg.sv
`default_nettype none

package mist_pkg;

	// ==================================================
	// Opcodes and modes
	// ==================================================
	typedef enum logic [7:0] {
		cmd_buttons = 8'h01,
		cmd_joy0    = 8'h02,
		cmd_joy1    = 8'h03,
		cmd_ps2_kbd = 8'h05,
		cmd_status  = 8'h1E
	} spi_cmd_e;

	typedef enum logic [1:0] {
		off,
		pct25,
		pct50,
		pct75
	} scan_mode_e;

	// ==================================================
	// Bundles
	// ==================================================
	typedef struct packed {
		logic       no_csync;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;             // Bit 1 is the board reset button
	} sw_cfg_t;

	// Bit 0 is right, bit 9 is fire_f
	typedef struct packed {
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic tilt;
		logic coin2;
		logic coin1;
		logic two_players;
		logic one_player;
	} ctrl_t;

	typedef struct packed {
		logic [7:0] luma;
		logic       hs;
		logic       vs;
		logic       hb;
		logic       vb;
	} video_in_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_t;

	typedef struct packed {
		logic reset_n;
		logic coin1_n;
		logic coin2_n;
		logic start_n;
		logic gas_n;
		logic gearup_n;
		logic geardown_n;
		logic left;
		logic right;
		logic test_n;
	} core_ctrl_t;

endpackage

`default_nettype wire

// File: common/mist_config.svh
`ifndef MIST_CONFIG_SVH
`define MIST_CONFIG_SVH

// ==================================================
// Widths
// ==================================================
`define DAC_BITS     7
`define COLOR_DEPTH  6
`define SPI_SYNC     2
`define STATUS_BITS  32

// ==================================================
// PS/2 set 2 scancodes
// ==================================================
`define KEY_BREAK    8'hF0 // Next code is a release
`define KEY_EXT      8'hE0 // Next code is extended
`define KEY_UP       8'h75
`define KEY_DOWN     8'h72
`define KEY_LEFT     8'h6B
`define KEY_RIGHT    8'h74
`define KEY_CTRL     8'h14
`define KEY_ALT      8'h11
`define KEY_SPACE    8'h29
`define KEY_1        8'h16
`define KEY_5        8'h2E
`define KEY_6        8'h36

`endif
